//--- source/eth_pkg.sv
package eth_pkg;

  // Line coding of the frame start
  localparam logic [3:0] PREAMBLE_NIBBLE = 4'h5;
  localparam logic [3:0] SFD_NIBBLE      = 4'hD;  // Completes the 8'hD5 delimiter

  localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
  // Good frame remainder, written in MSB-first bit order
  localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

  localparam int IPG_NIBBLES = 24;  // Idle clocks after every frame

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_PREAMBLE,
    TX_DATA,
    TX_FCS,
    TX_GAP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PREAMBLE,
    RX_DATA,
    RX_DROP
  } rx_state_e;

endpackage

//--- source/eth_byte_if.sv
`timescale 1ns/10ps

interface eth_byte_if;
  logic       valid;
  logic       ready;
  logic [7:0] data;
  logic       last;   // Marks the final byte of a frame

  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );
endinterface

//--- source/eth_crc32.sv
`timescale 1ns/10ps

module eth_crc32
  import eth_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        init_i,
  input  logic        en_i,
  input  logic [3:0]  nibble_i,
  output logic [31:0] crc_o
);

  localparam logic [31:0] POLY_REFL = 32'hEDB8_8320;

  logic [31:0] crc_q;
  logic [31:0] crc_next;

  // Four serial LFSR steps, nibble bit 0 goes in first
  always_comb begin
    crc_next = crc_q;
    for (int i = 0; i < 4; i++) begin
      if (crc_next[0] ^ nibble_i[i]) begin
        crc_next = (crc_next >> 1) ^ POLY_REFL;
      end else begin
        crc_next = crc_next >> 1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      crc_q <= CRC_INIT;
    end else if (init_i) begin
      crc_q <= CRC_INIT;  // Init wins over a pending nibble
    end else if (en_i) begin
      crc_q <= crc_next;
    end
  end

  assign crc_o = crc_q;

endmodule

//--- source/eth_byte_fifo.sv
`timescale 1ns/10ps

module eth_byte_fifo #(
  parameter int FIFO_ADDR_W = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  eth_byte_if.sink             wr,
  eth_byte_if.source           rd,
  output logic [FIFO_ADDR_W:0] frames_o
);

  localparam int DEPTH = 1 << FIFO_ADDR_W;

  logic [8:0]             mem_q [DEPTH];  // {last, data}
  logic [FIFO_ADDR_W:0]   wptr_q;
  logic [FIFO_ADDR_W:0]   rptr_q;
  logic [FIFO_ADDR_W:0]   used;
  logic [FIFO_ADDR_W:0]   frames_q;
  logic [8:0]             out_q;
  logic                   out_valid_q;
  logic                   push;
  logic                   pop_mem;
  logic                   pop_out;

  assign used     = wptr_q - rptr_q;
  assign wr.ready = !used[FIFO_ADDR_W];  // Top bit set only when full
  assign push     = wr.valid && wr.ready;
  assign pop_out  = out_valid_q && rd.ready;
  // Refill the output register whenever it empties or is taken
  assign pop_mem  = (used != '0) && (!out_valid_q || rd.ready);

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wptr_q[FIFO_ADDR_W-1:0]] <= {wr.last, wr.data};
    if (pop_mem) out_q <= mem_q[rptr_q[FIFO_ADDR_W-1:0]];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_q      <= '0;
      rptr_q      <= '0;
      out_valid_q <= 1'b0;
      frames_q    <= '0;
    end else begin
      if (push) wptr_q <= wptr_q + 1'b1;
      if (pop_mem) begin
        rptr_q      <= rptr_q + 1'b1;
        out_valid_q <= 1'b1;
      end else if (pop_out) begin
        out_valid_q <= 1'b0;
      end
      // Complete frames held anywhere in the buffer
      case ({push && wr.last, pop_out && out_q[8]})
        2'b10:   frames_q <= frames_q + 1'b1;
        2'b01:   frames_q <= frames_q - 1'b1;
        default: frames_q <= frames_q;
      endcase
    end
  end

  assign rd.valid = out_valid_q;
  assign rd.data  = out_q[7:0];
  assign rd.last  = out_q[8];
  assign frames_o = frames_q;

endmodule

//--- source/eth_tx.sv
`timescale 1ns/10ps

module eth_tx
  import eth_pkg::*;
#(
  parameter int FIFO_ADDR_W = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  eth_byte_if.sink             in,
  input  logic [FIFO_ADDR_W:0] frames_i,
  output logic [3:0]           mii_txd_o,
  output logic                 mii_tx_en_o
);

  tx_state_e   state_q;
  logic [4:0]  cnt_q;     // Preamble, FCS and gap position
  logic [3:0]  hi_nib_q;  // High nibble of the byte on the wire
  logic        hi_q;      // High nibble goes out next
  logic        last_q;
  logic [31:0] fcs_q;
  logic [31:0] crc;
  logic        pop;
  logic        crc_en;
  logic [3:0]  crc_nib;

  // Byte taken while the SFD is on the wire and after each high nibble
  assign pop = (state_q == TX_PREAMBLE && cnt_q == 5'd15) ||
               (state_q == TX_DATA && !hi_q && !last_q);
  assign in.ready = pop;

  // Every payload nibble enters the CRC as it is loaded onto the bus
  assign crc_en  = pop || (state_q == TX_DATA && hi_q);
  assign crc_nib = pop ? in.data[3:0] : hi_nib_q;

  eth_crc32 crc_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .init_i  (state_q == TX_IDLE),
    .en_i    (crc_en),
    .nibble_i(crc_nib),
    .crc_o   (crc)
  );

  always_ff @(posedge clk_i) begin
    if (pop) hi_nib_q <= in.data[7:4];
    // FCS is sent complemented, LSB nibble first
    if (state_q == TX_DATA && !hi_q && last_q) begin
      fcs_q <= ~crc >> 4;
    end else if (state_q == TX_FCS) begin
      fcs_q <= fcs_q >> 4;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= TX_IDLE;
      cnt_q       <= '0;
      hi_q        <= 1'b0;
      last_q      <= 1'b0;
      mii_txd_o   <= '0;
      mii_tx_en_o <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (frames_i != '0 && in.valid) begin
            state_q     <= TX_PREAMBLE;
            cnt_q       <= '0;
            mii_tx_en_o <= 1'b1;
            mii_txd_o   <= PREAMBLE_NIBBLE;
          end
        end
        TX_PREAMBLE: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == 5'd14) begin
            mii_txd_o <= SFD_NIBBLE;
          end else if (pop) begin
            state_q   <= TX_DATA;
            mii_txd_o <= in.data[3:0];
            hi_q      <= 1'b1;
            last_q    <= in.last;
          end else begin
            mii_txd_o <= PREAMBLE_NIBBLE;
          end
        end
        TX_DATA: begin
          if (hi_q) begin
            mii_txd_o <= hi_nib_q;
            hi_q      <= 1'b0;
          end else if (last_q) begin
            state_q   <= TX_FCS;
            cnt_q     <= '0;
            mii_txd_o <= ~crc[3:0];
          end else begin
            mii_txd_o <= in.data[3:0];
            hi_q      <= 1'b1;
            last_q    <= in.last;
          end
        end
        TX_FCS: begin
          if (cnt_q == 5'd7) begin
            state_q     <= TX_GAP;
            cnt_q       <= '0;
            mii_tx_en_o <= 1'b0;
            mii_txd_o   <= '0;
          end else begin
            cnt_q     <= cnt_q + 1'b1;
            mii_txd_o <= fcs_q[3:0];
          end
        end
        TX_GAP: begin
          if (cnt_q == 5'(IPG_NIBBLES - 1)) state_q <= TX_IDLE;
          else cnt_q <= cnt_q + 1'b1;
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

//--- source/eth_rx.sv
`timescale 1ns/10ps

module eth_rx
  import eth_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  eth_byte_if.source out,
  input  logic [3:0] mii_rxd_i,
  input  logic       mii_rx_dv_i,
  output logic       frame_done_o,
  output logic       crc_err_o
);

  rx_state_e   state_q;
  logic        hi_q;            // Next nibble completes a byte
  logic [3:0]  lo_q;
  logic [7:0]  dline_q [4];     // Newest byte in slot 0
  logic [2:0]  fill_q;
  logic [7:0]  pend_q;          // Byte waiting to learn if it is last
  logic        pend_valid_q;
  logic [7:0]  out_data_q;
  logic        out_last_q;
  logic        out_valid_q;
  logic [31:0] crc;
  logic [31:0] crc_msb_first;   // Register is reflected
  logic        byte_done;
  logic        dv_end;
  logic        emit;

  assign byte_done = state_q == RX_DATA && mii_rx_dv_i && hi_q;
  assign dv_end    = state_q == RX_DATA && !mii_rx_dv_i;
  assign emit      = pend_valid_q && ((byte_done && fill_q == 3'd4) || dv_end);
  assign crc_msb_first = {<<{crc}};

  eth_crc32 crc_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .init_i  (state_q != RX_DATA),
    .en_i    (state_q == RX_DATA && mii_rx_dv_i),
    .nibble_i(mii_rxd_i),
    .crc_o   (crc)
  );

  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && mii_rx_dv_i && !hi_q) lo_q <= mii_rxd_i;
    if (byte_done) begin
      dline_q[0] <= {mii_rxd_i, lo_q};
      for (int i = 1; i < 4; i++) begin
        dline_q[i] <= dline_q[i-1];
      end
      if (fill_q == 3'd4) pend_q <= dline_q[3];
    end
    if (emit) begin
      out_data_q <= pend_q;
      out_last_q <= dv_end;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= RX_IDLE;
      hi_q         <= 1'b0;
      fill_q       <= '0;
      pend_valid_q <= 1'b0;
      out_valid_q  <= 1'b0;
      frame_done_o <= 1'b0;
      crc_err_o    <= 1'b0;
    end else begin
      frame_done_o <= 1'b0;
      crc_err_o    <= 1'b0;
      // No stall on MII so a new byte overwrites a refused one
      if (emit) out_valid_q <= 1'b1;
      else if (out.ready) out_valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          hi_q         <= 1'b0;
          fill_q       <= '0;
          pend_valid_q <= 1'b0;
          if (mii_rx_dv_i) begin
            state_q <= (mii_rxd_i == PREAMBLE_NIBBLE) ? RX_PREAMBLE : RX_DROP;
          end
        end
        RX_PREAMBLE: begin
          if (!mii_rx_dv_i) state_q <= RX_IDLE;
          else if (mii_rxd_i == SFD_NIBBLE) state_q <= RX_DATA;
          else if (mii_rxd_i != PREAMBLE_NIBBLE) state_q <= RX_DROP;
        end
        RX_DATA: begin
          if (dv_end) begin
            state_q      <= RX_IDLE;
            frame_done_o <= 1'b1;
            crc_err_o    <= crc_msb_first != CRC_RESIDUE;
          end else begin
            hi_q <= !hi_q;
            if (byte_done) begin
              if (fill_q != 3'd4) fill_q <= fill_q + 1'b1;
              else pend_valid_q <= 1'b1;  // Delay line full of FCS candidates
            end
          end
        end
        RX_DROP: begin
          if (!mii_rx_dv_i) state_q <= RX_IDLE;
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  assign out.valid = out_valid_q;
  assign out.data  = out_data_q;
  assign out.last  = out_last_q;

endmodule

//--- source/eth_core.sv
`timescale 1ns/10ps

module eth_core #(
  parameter int FIFO_ADDR_W = 8
) (
  input  logic       clk_i,
  input  logic       rst_i,
  // Host transmit stream
  input  logic       tx_valid_i,
  output logic       tx_ready_o,
  input  logic [7:0] tx_data_i,
  input  logic       tx_last_i,
  // Host receive stream
  output logic       rx_valid_o,
  input  logic       rx_ready_i,
  output logic [7:0] rx_data_o,
  output logic       rx_last_o,
  // MII
  output logic [3:0] mii_txd_o,
  output logic       mii_tx_en_o,
  input  logic [3:0] mii_rxd_i,
  input  logic       mii_rx_dv_i,
  output logic       rx_frame_done_o,
  output logic       rx_crc_err_o
);

  logic [FIFO_ADDR_W:0] tx_frames;

  eth_byte_if host_tx_if ();
  eth_byte_if tx_if ();
  eth_byte_if rx_if ();
  eth_byte_if host_rx_if ();

  assign host_tx_if.valid = tx_valid_i;
  assign host_tx_if.data  = tx_data_i;
  assign host_tx_if.last  = tx_last_i;
  assign tx_ready_o       = host_tx_if.ready;

  assign rx_valid_o       = host_rx_if.valid;
  assign rx_data_o        = host_rx_if.data;
  assign rx_last_o        = host_rx_if.last;
  assign host_rx_if.ready = rx_ready_i;

  eth_byte_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) tx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wr      (host_tx_if),
    .rd      (tx_if),
    .frames_o(tx_frames)
  );

  eth_tx #(.FIFO_ADDR_W(FIFO_ADDR_W)) tx_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in         (tx_if),
    .frames_i   (tx_frames),
    .mii_txd_o  (mii_txd_o),
    .mii_tx_en_o(mii_tx_en_o)
  );

  eth_rx rx_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .out         (rx_if),
    .mii_rxd_i   (mii_rxd_i),
    .mii_rx_dv_i (mii_rx_dv_i),
    .frame_done_o(rx_frame_done_o),
    .crc_err_o   (rx_crc_err_o)
  );

  // Frame count not needed on the receive side
  eth_byte_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) rx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wr      (rx_if),
    .rd      (host_rx_if),
    .frames_o()
  );

endmodule

//--- bench/eth_core_properties.sv
`timescale 1ns/10ps

module eth_core_properties
  import eth_pkg::*;
(
  input logic       clk_i,
  input logic       rst_i,
  input logic       tx_valid_i,
  input logic       tx_ready_o,
  input logic [7:0] tx_data_i,
  input logic       tx_last_i,
  input logic       rx_valid_o,
  input logic       rx_ready_i,
  input logic [7:0] rx_data_o,
  input logic       rx_last_o,
  input logic       mii_tx_en_o,
  input logic       rx_frame_done_o,
  input logic       rx_crc_err_o
);

  logic [7:0] idle_q;  // Idle clocks on the MII transmit side, saturating
  int         fail_cnt = 0;  // Failed assertions so far

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      idle_q <= '1;
    end else if (mii_tx_en_o) begin
      idle_q <= '0;
    end else if (idle_q != '1) begin
      idle_q <= idle_q + 8'd1;
    end
  end

  tx_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_valid_i && !tx_ready_o |=> tx_valid_i && $stable(tx_data_i) && $stable(tx_last_i))
    else begin
      fail_cnt++;
      $error("host tx byte dropped or changed before it was accepted");
    end

  rx_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_valid_o && !rx_ready_i |=> rx_valid_o && $stable(rx_data_o) && $stable(rx_last_o))
    else begin
      fail_cnt++;
      $error("host rx byte dropped or changed before it was taken");
    end

  // A new frame may only start after the full inter-packet gap
  ipg_min: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(mii_tx_en_o) |-> idle_q >= IPG_NIBBLES)
    else begin
      fail_cnt++;
      $error("mii_tx_en_o rose after only %0d idle cycles", $sampled(idle_q));
    end

  err_with_done: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_crc_err_o |-> rx_frame_done_o)
    else begin
      fail_cnt++;
      $error("rx_crc_err_o high without rx_frame_done_o");
    end

endmodule

bind eth_core eth_core_properties props_i (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .tx_valid_i     (tx_valid_i),
  .tx_ready_o     (tx_ready_o),
  .tx_data_i      (tx_data_i),
  .tx_last_i      (tx_last_i),
  .rx_valid_o     (rx_valid_o),
  .rx_ready_i     (rx_ready_i),
  .rx_data_o      (rx_data_o),
  .rx_last_o      (rx_last_o),
  .mii_tx_en_o    (mii_tx_en_o),
  .rx_frame_done_o(rx_frame_done_o),
  .rx_crc_err_o   (rx_crc_err_o)
);

//--- bench/tb_eth_core.sv
`timescale 1ns/10ps

module tb_eth_core
  import eth_pkg::*;
();

  typedef logic [7:0] bytes_t[$];
  typedef logic [3:0] nibbles_t[$];

  localparam int CLK_PERIOD = 40;
  // Preamble, FCS, gap and the FIFO plus delay line latency
  localparam int FRAME_OVERHEAD = 16 + 8 + IPG_NIBBLES + 24;
  localparam int TOTAL_BYTES = 20 + 12 + 3 * 39 + 2 * 16;
  localparam int NUM_FRAMES = 7;
  localparam int WATCHDOG_CYCLES = 4 * (2 * TOTAL_BYTES + NUM_FRAMES * FRAME_OVERHEAD);

  logic       clk;
  logic       rst;
  logic       tx_valid;
  logic       tx_ready;
  logic [7:0] tx_data;
  logic       tx_last;
  logic       rx_valid;
  logic       rx_ready;
  logic [7:0] rx_data;
  logic       rx_last;
  logic [3:0] mii_txd;
  logic       mii_tx_en;
  logic [3:0] mii_rxd;
  logic       mii_rx_dv;
  logic       frame_done;
  logic       crc_err;
  logic       mii_direct;    // Test drives the MII input instead of loopback
  logic [3:0] drv_rxd;
  logic       drv_dv;
  bit         rand_ready = 1'b0;
  integer     seed = 32'h7162;

  // Observed traffic, filled at falling edges
  logic [7:0] rx_bytes[$];
  logic       rx_lasts[$];
  logic [3:0] wire_q[$];
  int         len_q[$];
  int rx_frames;
  int done_cnt;
  int crc_err_cnt;
  int min_gap;
  int err_cnt = 0;
  int tests_run = 0;
  int tests_failed = 0;

  assign mii_rxd   = mii_direct ? drv_rxd : mii_txd;
  assign mii_rx_dv = mii_direct ? drv_dv : mii_tx_en;

  eth_core #(.FIFO_ADDR_W(8)) dut_i (
    .clk_i          (clk),
    .rst_i          (rst),
    .tx_valid_i     (tx_valid),
    .tx_ready_o     (tx_ready),
    .tx_data_i      (tx_data),
    .tx_last_i      (tx_last),
    .rx_valid_o     (rx_valid),
    .rx_ready_i     (rx_ready),
    .rx_data_o      (rx_data),
    .rx_last_o      (rx_last),
    .mii_txd_o      (mii_txd),
    .mii_tx_en_o    (mii_tx_en),
    .mii_rxd_i      (mii_rxd),
    .mii_rx_dv_i    (mii_rx_dv),
    .rx_frame_done_o(frame_done),
    .rx_crc_err_o   (crc_err)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // Host receive ready, random only while a test asks for back-pressure
  initial begin
    rx_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      rx_ready = rand_ready ? 1'($random(seed)) : 1'b1;
    end
  end

  initial begin
    int en_run;
    int idle_run;
    bit en_prev;
    bit seen_frame;
    en_run = 0;
    idle_run = 0;
    en_prev = 1'b0;
    seen_frame = 1'b0;
    forever begin
      @(negedge clk);
      if (rx_valid && rx_ready) begin
        rx_bytes.push_back(rx_data);
        rx_lasts.push_back(rx_last);
        if (rx_last) rx_frames++;
      end
      if (frame_done) done_cnt++;
      if (crc_err) crc_err_cnt++;
      if (mii_tx_en) begin
        if (!en_prev && seen_frame && idle_run < min_gap) min_gap = idle_run;
        wire_q.push_back(mii_txd);
        en_run++;
        idle_run = 0;
      end else begin
        if (en_prev) begin
          len_q.push_back(en_run);
          seen_frame = 1'b1;
        end
        en_run = 0;
        idle_run++;
      end
      en_prev = mii_tx_en;
    end
  end

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      $display("error at %0d ns: %s", $time, msg);
      err_cnt++;
    end
  endtask

  // Bitwise reference CRC over whole bytes, returns the FCS value
  function automatic logic [31:0] fcs_of(input bytes_t p);
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    foreach (p[i]) begin
      c = c ^ {24'h0, p[i]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? (c >> 1) ^ 32'hEDB8_8320 : c >> 1;
      end
    end
    return ~c;
  endfunction

  function automatic bytes_t random_frame(input int len);
    bytes_t p;
    for (int i = 0; i < len; i++) p.push_back(8'($random(seed)));
    return p;
  endfunction

  // Nibbles as they appear on the wire while tx_en is high
  function automatic nibbles_t wire_nibbles(input bytes_t p);
    nibbles_t n;
    logic [31:0] fcs;
    fcs = fcs_of(p);
    for (int i = 0; i < 15; i++) n.push_back(4'h5);
    n.push_back(4'hD);
    foreach (p[i]) begin
      n.push_back(p[i][3:0]);
      n.push_back(p[i][7:4]);
    end
    for (int k = 0; k < 8; k++) n.push_back(fcs[4 * k +: 4]);  // FCS bit 0 leaves first
    return n;
  endfunction

  function automatic int frame_limit(input int n);
    return 4 * (2 * n + FRAME_OVERHEAD);
  endfunction

  task automatic clear_monitors();
    rx_bytes.delete();
    rx_lasts.delete();
    wire_q.delete();
    len_q.delete();
    rx_frames = 0;
    done_cnt = 0;
    crc_err_cnt = 0;
    min_gap = 1000;
  endtask

  task automatic send_frame(input bytes_t p);
    bit taken;
    foreach (p[i]) begin
      tx_valid = 1'b1;
      tx_data  = p[i];
      tx_last  = (i == p.size() - 1);
      do begin
        @(negedge clk);
        taken = tx_ready;
        step();
      end while (!taken);
    end
    tx_valid = 1'b0;
    tx_last  = 1'b0;
  endtask

  task automatic drive_mii(input nibbles_t n);
    foreach (n[i]) begin
      drv_rxd = n[i];
      drv_dv  = 1'b1;
      step();
    end
    drv_dv  = 1'b0;
    drv_rxd = 4'h0;
  endtask

  task automatic set_rand_ready(input bit on);
    @(negedge clk);
    rand_ready = on;
    step();
  endtask

  task automatic wait_rx_frames(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (rx_frames < n && cycles < limit) begin
      step();
      cycles++;
    end
    if (rx_frames < n) begin
      $display("timeout: only %0d of %0d frames came back within %0d cycles",
               rx_frames, n, limit);
      err_cnt++;
    end
  endtask

  task automatic check_rx_frame(input bytes_t p);
    logic [7:0] d;
    logic       l;
    if (rx_bytes.size() < p.size()) begin
      check(1'b0, $sformatf("received %0d bytes, expected %0d", rx_bytes.size(), p.size()));
    end else begin
      foreach (p[i]) begin
        d = rx_bytes.pop_front();
        l = rx_lasts.pop_front();
        check(d == p[i], $sformatf("rx byte %0d is %h, expected %h", i, d, p[i]));
        check(l == (i == p.size() - 1), $sformatf("rx byte %0d has last %b", i, l));
      end
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic test_reset_state();
    int errs;
    errs = err_cnt;
    check(mii_tx_en === 1'b0, "mii_tx_en_o not low after reset");
    check(rx_valid === 1'b0, "rx_valid_o not low after reset");
    check(frame_done === 1'b0, "rx_frame_done_o not low after reset");
    check(crc_err === 1'b0, "rx_crc_err_o not low after reset");
    check(tx_ready === 1'b1, "tx_ready_o not high after reset");
    end_test("reset state", errs);
  endtask

  task automatic test_loopback();
    bytes_t p;
    int errs;
    errs = err_cnt;
    clear_monitors();
    p = random_frame(20);
    send_frame(p);
    wait_rx_frames(1, frame_limit(20));
    check_rx_frame(p);
    check(rx_bytes.size() == 0, $sformatf("%0d extra rx bytes", rx_bytes.size()));
    check(done_cnt == 1, $sformatf("%0d frame done pulses, expected 1", done_cnt));
    check(crc_err_cnt == 0, "CRC error on a clean loopback frame");
    end_test("single frame loopback", errs);
  endtask

  task automatic test_wire_format();
    bytes_t   p;
    nibbles_t exp;
    int errs;
    errs = err_cnt;
    clear_monitors();
    p = random_frame(12);
    exp = wire_nibbles(p);
    send_frame(p);
    wait_rx_frames(1, frame_limit(12));
    check(len_q.size() == 1, $sformatf("%0d transmissions seen, expected 1", len_q.size()));
    if (len_q.size() == 1) begin
      check(len_q[0] == 16 + 2 * 12 + 8, $sformatf("tx_en high for %0d cycles", len_q[0]));
    end
    check(wire_q.size() == exp.size(), $sformatf("%0d nibbles on the wire", wire_q.size()));
    foreach (exp[i]) begin
      if (i < wire_q.size()) begin
        check(wire_q[i] == exp[i],
              $sformatf("wire nibble %0d is %h, expected %h", i, wire_q[i], exp[i]));
      end
    end
    check_rx_frame(p);
    end_test("wire format", errs);
  endtask

  task automatic test_back_to_back();
    bytes_t f0;
    bytes_t f1;
    bytes_t f2;
    int total;
    int errs;
    errs = err_cnt;
    clear_monitors();
    f0 = random_frame(8 + ($random(seed) & 31));
    f1 = random_frame(8 + ($random(seed) & 31));
    f2 = random_frame(8 + ($random(seed) & 31));
    total = f0.size() + f1.size() + f2.size();
    set_rand_ready(1'b1);
    send_frame(f0);
    send_frame(f1);
    send_frame(f2);
    wait_rx_frames(3, 4 * (2 * total + 3 * FRAME_OVERHEAD));
    set_rand_ready(1'b0);
    check_rx_frame(f0);
    check_rx_frame(f1);
    check_rx_frame(f2);
    check(done_cnt == 3, $sformatf("%0d frame done pulses, expected 3", done_cnt));
    check(crc_err_cnt == 0, "CRC error on clean back to back frames");
    check(len_q.size() == 3, $sformatf("%0d transmissions seen, expected 3", len_q.size()));
    check(min_gap >= IPG_NIBBLES, $sformatf("gap of only %0d idle cycles", min_gap));
    end_test("back to back frames", errs);
  endtask

  task automatic test_corrupt_frame();
    bytes_t   p;
    nibbles_t n;
    int errs;
    errs = err_cnt;
    clear_monitors();
    mii_direct = 1'b1;
    p = random_frame(16);
    n = wire_nibbles(p);
    n[21] = n[21] ^ 4'h8;  // Payload byte 2, high nibble
    drive_mii(n);
    wait_rx_frames(1, frame_limit(16));
    check(done_cnt == 1, $sformatf("%0d frame done pulses, expected 1", done_cnt));
    check(crc_err_cnt == 1, "no CRC error on a corrupted frame");
    repeat (IPG_NIBBLES) step();
    clear_monitors();
    p = random_frame(16);
    drive_mii(wire_nibbles(p));
    wait_rx_frames(1, frame_limit(16));
    check(done_cnt == 1, $sformatf("%0d frame done pulses, expected 1", done_cnt));
    check(crc_err_cnt == 0, "CRC error on the clean frame after a bad one");
    check_rx_frame(p);
    mii_direct = 1'b0;
    end_test("corrupted frame", errs);
  endtask

  initial begin
    rst        = 1'b1;
    tx_valid   = 1'b0;
    tx_data    = 8'h00;
    tx_last    = 1'b0;
    mii_direct = 1'b0;
    drv_rxd    = 4'h0;
    drv_dv     = 1'b0;
    clear_monitors();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    test_reset_state();
    test_loopback();
    test_wire_format();
    test_back_to_back();
    test_corrupt_frame();
    $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
             tests_run, tests_failed, err_cnt, dut_i.props_i.fail_cnt);
    if (err_cnt == 0 && dut_i.props_i.fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
source/eth_pkg.sv
source/eth_byte_if.sv
source/eth_crc32.sv
source/eth_byte_fifo.sv
source/eth_tx.sv
source/eth_rx.sv
source/eth_core.sv
bench/eth_core_properties.sv
bench/tb_eth_core.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_core -f sim.f \
  -o tb_eth_core > sim.log 2>&1 \
  && ./obj_dir/tb_eth_core >> sim.log 2>&1 \
  || echo "build or simulation stopped with an error" >> sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
